/* verif/axi_rd_stim.txt */
# test port(0=a 1=b 2=c 3=d) id(hex) addr(hex) len size rready(0 high, 1 random, 2 held low)
# one read burst per line; lines with the same test number run together
1 0 3 00001000 3 3 0
2 1 3 00002000 7 3 0
3 2 9 00003004 2 2 0
4 3 f 00004000 0 3 0
5 0 a 00010000 1 3 0
5 1 a 00020000 2 3 0
5 2 a 00030000 3 3 0
5 3 a 00040000 1 2 0
5 0 b 00010100 2 3 0
5 1 b 00020100 0 3 0
5 2 b 00030100 1 1 0
5 3 b 00040100 3 3 0
6 0 1 00100000 3 3 1
6 1 2 00200000 2 3 1
6 2 4 00300000 4 2 1
6 3 5 00400000 1 3 1
6 0 6 00100040 1 3 1
6 1 7 00200040 3 3 1
6 2 8 00300040 0 3 1
6 3 9 00400040 2 3 1
7 0 0 00500000 1 3 2
7 0 1 00500020 0 3 2
7 0 2 00500040 1 3 2
7 0 3 00500060 0 3 2
7 0 4 00500080 1 3 2
7 0 5 005000a0 0 3 2
7 0 6 005000c0 1 3 2
7 0 7 005000e0 0 3 2
7 0 8 00500100 1 3 2
7 0 9 00500120 0 3 2
7 0 a 00500140 1 3 2
7 0 b 00500160 0 3 2
8 2 c 80000000 3 3 0
8 3 d 80001000 1 2 0

/* list.f */
common/axi_rd_pkg.sv
design/rd_sync_fifo.sv
merger/rd_port_tracker.sv
merger/axi_rd_4_merger.sv
design/axi_rd_mem_responder.sv
design/axi_rd_subsys_top.sv
verif/tb_axi_rd_subsys.sv

/* Makefile */
# Verilator build and run for the AXI read merger subsystem

VERILATOR ?= verilator
TOP       ?= tb_axi_rd_subsys
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 -Wno-fatal
STIM      ?= verif/axi_rd_stim.txt

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(OBJ_DIR)

run: $(SIM_BIN) $(STIM)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/tb_axi_rd_subsys.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_axi_rd_subsys;

    localparam int MAX_OUTSTANDING = 8;
    localparam int WAIT_LIMIT = 500;
    localparam int HOLD_CYCLES = 60;

    typedef struct {
        int test;
        int port;
        int mode;
        axi_rd_pkg::ar_req_t req;
    } stim_t;

    logic clk = 1'b0;
    logic rst_n;
    logic [axi_rd_pkg::ID_W-1:0] arid [4];
    logic [axi_rd_pkg::ADDR_W-1:0] araddr [4];
    logic [7:0] arlen [4];
    logic [2:0] arsize [4];
    logic [1:0] arburst [4];
    logic arvalid [4];
    logic arready [4];
    logic [axi_rd_pkg::ID_W-1:0] rid [4];
    logic [axi_rd_pkg::DATA_W-1:0] rdata [4];
    logic [1:0] rresp [4];
    logic rlast [4];
    logic rvalid [4];
    logic rready [4];

    string pname [4] = '{"a", "b", "c", "d"};
    stim_t stim_q [$];
    axi_rd_pkg::ar_req_t issue_q [4][$];
    axi_rd_pkg::ar_req_t expect_q [4][$];
    int rmode [4] = '{0, 0, 0, 0};
    int inflight [4] = '{0, 0, 0, 0};
    int seed = 37348;
    int errors = 0;
    int test_errors = 0;
    int test_beats = 0;
    logic stuck = 1'b0;
    logic hold_release;

    always #20 clk = ~clk;

    axi_rd_subsys_top #(
        .MAX_OUTSTANDING(MAX_OUTSTANDING),
        .AR_DEPTH(2),
        .BEAT_DEPTH(2)
    ) dut_i (
        .clk(clk), .rst_n(rst_n),
        .a_arid(arid[0]), .b_arid(arid[1]), .c_arid(arid[2]), .d_arid(arid[3]),
        .a_araddr(araddr[0]), .b_araddr(araddr[1]), .c_araddr(araddr[2]), .d_araddr(araddr[3]),
        .a_arlen(arlen[0]), .b_arlen(arlen[1]), .c_arlen(arlen[2]), .d_arlen(arlen[3]),
        .a_arsize(arsize[0]), .b_arsize(arsize[1]), .c_arsize(arsize[2]), .d_arsize(arsize[3]),
        .a_arburst(arburst[0]), .b_arburst(arburst[1]),
        .c_arburst(arburst[2]), .d_arburst(arburst[3]),
        .a_arvalid(arvalid[0]), .b_arvalid(arvalid[1]),
        .c_arvalid(arvalid[2]), .d_arvalid(arvalid[3]),
        .a_arready(arready[0]), .b_arready(arready[1]),
        .c_arready(arready[2]), .d_arready(arready[3]),
        .a_rid(rid[0]), .b_rid(rid[1]), .c_rid(rid[2]), .d_rid(rid[3]),
        .a_rdata(rdata[0]), .b_rdata(rdata[1]), .c_rdata(rdata[2]), .d_rdata(rdata[3]),
        .a_rresp(rresp[0]), .b_rresp(rresp[1]), .c_rresp(rresp[2]), .d_rresp(rresp[3]),
        .a_rlast(rlast[0]), .b_rlast(rlast[1]), .c_rlast(rlast[2]), .d_rlast(rlast[3]),
        .a_rvalid(rvalid[0]), .b_rvalid(rvalid[1]), .c_rvalid(rvalid[2]), .d_rvalid(rvalid[3]),
        .a_rready(rready[0]), .b_rready(rready[1]), .c_rready(rready[2]), .d_rready(rready[3])
    );

    task automatic check_beat_data(input string name, input logic [axi_rd_pkg::DATA_W-1:0] got,
                                   input logic [axi_rd_pkg::DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_id(input string name, input logic [axi_rd_pkg::ID_W-1:0] got,
                            input logic [axi_rd_pkg::ID_W-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic read_stim();
        int fd;
        int n;
        string line;
        stim_t s;
        logic [31:0] id_v;
        logic [31:0] addr_v;
        int len_v;
        int size_v;
        fd = $fopen("verif/axi_rd_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file verif/axi_rd_stim.txt");
            errors++;
            stuck = 1'b1;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // comment and blank lines are skipped
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%d %d %h %h %d %d %d", s.test, s.port, id_v, addr_v,
                            len_v, size_v, s.mode);
                if (n == 7) begin
                    s.req.id = id_v[axi_rd_pkg::ID_W-1:0];
                    s.req.addr = addr_v;
                    s.req.len = 8'(len_v);
                    s.req.size = 3'(size_v);
                    s.req.burst = 2'b01;
                    stim_q.push_back(s);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic issue_port(input int p);
        axi_rd_pkg::ar_req_t r;
        int waited;
        while (issue_q[p].size() > 0 && !stuck) begin
            r = issue_q[p].pop_front();
            arid[p] <= r.id;
            araddr[p] <= r.addr;
            arlen[p] <= r.len;
            arsize[p] <= r.size;
            arburst[p] <= r.burst;
            arvalid[p] <= 1'b1;
            waited = 0;
            @(negedge clk);
            while (!arready[p] && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (!arready[p]) begin
                $display("port %s: request with id %h was never accepted", pname[p], r.id);
                test_errors++;
                stuck = 1'b1;
            end
            @(posedge clk);
        end
        arvalid[p] <= 1'b0;
        issue_q[p].delete();
    endtask

    task automatic collect_port(input int p);
        axi_rd_pkg::ar_req_t r;
        logic [axi_rd_pkg::ADDR_W-1:0] addr;
        int waited;
        while (expect_q[p].size() > 0 && !stuck) begin
            r = expect_q[p].pop_front();
            for (int b = 0; b <= int'(r.len); b++) begin
                waited = 0;
                @(negedge clk);
                while (!(rvalid[p] && rready[p]) && waited < WAIT_LIMIT) begin
                    @(negedge clk);
                    waited++;
                end
                if (!(rvalid[p] && rready[p])) begin
                    $display("port %s: no beat %0d arrived for burst id %h", pname[p], b, r.id);
                    test_errors++;
                    stuck = 1'b1;
                    return;
                end
                // INCR walk with the inverted address in the upper data half
                addr = r.addr + (axi_rd_pkg::ADDR_W'(b) << r.size);
                check_beat_data({pname[p], "_rdata"}, rdata[p], {~addr, addr});
                check_resp({pname[p], "_rresp"}, rresp[p],
                           r.addr[31] ? axi_rd_pkg::RESP_SLVERR : axi_rd_pkg::RESP_OKAY);
                check_id({pname[p], "_rid"}, rid[p], r.id);
                check_last({pname[p], "_rlast"}, rlast[p], b == int'(r.len));
                test_beats++;
            end
        end
    endtask

    task automatic release_hold();
        hold_release <= 1'b0;
        repeat (HOLD_CYCLES) @(posedge clk);
        hold_release <= 1'b1;
    endtask

    initial begin : rready_drive
        logic [31:0] rnd;
        for (int p = 0; p < 4; p++) begin
            rready[p] <= 1'b0;
        end
        forever begin
            @(posedge clk);
            for (int p = 0; p < 4; p++) begin
                rnd = $random(seed);
                case (rmode[p])
                    1: rready[p] <= rnd[0];
                    2: rready[p] <= hold_release;
                    default: rready[p] <= 1'b1;
                endcase
            end
        end
    end

    // accepted but unfinished reads counted one edge ahead of the handshake
    always @(negedge clk) begin
        for (int p = 0; p < 4; p++) begin
            if (rst_n && arvalid[p] && arready[p]) begin
                inflight[p]++;
            end
            if (rst_n && rvalid[p] && rready[p] && rlast[p]) begin
                inflight[p]--;
            end
            if (inflight[p] > MAX_OUTSTANDING) begin
                $display("port %s has %0d reads outstanding, above the limit of %0d",
                         pname[p], inflight[p], MAX_OUTSTANDING);
                test_errors++;
            end
        end
    end

    initial begin : main
        int tests_run;
        int cur;
        int idx;
        int waited;
        tests_run = 0;
        rst_n <= 1'b0;
        hold_release <= 1'b0;
        for (int p = 0; p < 4; p++) begin
            arid[p] <= '0;
            araddr[p] <= '0;
            arlen[p] <= '0;
            arsize[p] <= '0;
            arburst[p] <= '0;
            arvalid[p] <= 1'b0;
        end
        read_stim();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // test 0 covers the state right after reset
        @(negedge clk);
        if (dut_i.arvalid !== 1'b0) begin
            $display("downstream arvalid is not low after reset");
            test_errors++;
        end
        for (int p = 0; p < 4; p++) begin
            if (rvalid[p] !== 1'b0) begin
                $display("port %s rvalid is not low after reset", pname[p]);
                test_errors++;
            end
            waited = 0;
            while (arready[p] !== 1'b1 && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (arready[p] !== 1'b1) begin
                $display("port %s arready never rose after reset", pname[p]);
                test_errors++;
                stuck = 1'b1;
            end
        end
        $display("test 0: %0d beats, %0d errors", test_beats, test_errors);
        errors += test_errors;
        tests_run++;

        idx = 0;
        while (idx < stim_q.size() && !stuck) begin
            cur = stim_q[idx].test;
            test_errors = 0;
            test_beats = 0;
            for (int p = 0; p < 4; p++) begin
                rmode[p] <= 0;
            end
            while (idx < stim_q.size() && stim_q[idx].test == cur) begin
                issue_q[stim_q[idx].port].push_back(stim_q[idx].req);
                expect_q[stim_q[idx].port].push_back(stim_q[idx].req);
                rmode[stim_q[idx].port] <= stim_q[idx].mode;
                idx++;
            end
            @(posedge clk);
            fork
                issue_port(0);
                issue_port(1);
                issue_port(2);
                issue_port(3);
                collect_port(0);
                collect_port(1);
                collect_port(2);
                collect_port(3);
                release_hold();
            join
            $display("test %0d: %0d beats, %0d errors", cur, test_beats, test_errors);
            errors += test_errors;
            tests_run++;
        end

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/axi_rd_subsys_top.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_rd_subsys_top #(
    parameter int MAX_OUTSTANDING = 8,
    parameter int AR_DEPTH = 2,
    parameter int BEAT_DEPTH = 2
) (
    input  logic clk,
    input  logic rst_n,

    input  logic [axi_rd_pkg::ID_W-1:0]   a_arid, b_arid, c_arid, d_arid,
    input  logic [axi_rd_pkg::ADDR_W-1:0] a_araddr, b_araddr, c_araddr, d_araddr,
    input  logic [7:0]                    a_arlen, b_arlen, c_arlen, d_arlen,
    input  logic [2:0]                    a_arsize, b_arsize, c_arsize, d_arsize,
    input  logic [1:0]                    a_arburst, b_arburst, c_arburst, d_arburst,
    input  logic                          a_arvalid, b_arvalid, c_arvalid, d_arvalid,
    output logic                          a_arready, b_arready, c_arready, d_arready,
    output logic [axi_rd_pkg::ID_W-1:0]   a_rid, b_rid, c_rid, d_rid,
    output logic [axi_rd_pkg::DATA_W-1:0] a_rdata, b_rdata, c_rdata, d_rdata,
    output logic [1:0]                    a_rresp, b_rresp, c_rresp, d_rresp,
    output logic                          a_rlast, b_rlast, c_rlast, d_rlast,
    output logic                          a_rvalid, b_rvalid, c_rvalid, d_rvalid,
    input  logic                          a_rready, b_rready, c_rready, d_rready
);

    // downstream link between merger and responder
    logic [axi_rd_pkg::ID_W-1:0] arid;
    logic [axi_rd_pkg::ADDR_W-1:0] araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic arvalid;
    logic arready;
    logic [axi_rd_pkg::ID_W-1:0] rid;
    logic [axi_rd_pkg::DATA_W-1:0] rdata;
    logic [1:0] rresp;
    logic rlast;
    logic rvalid;
    logic rready;

    axi_rd_4_merger #(
        .MAX_OUTSTANDING(MAX_OUTSTANDING),
        .AR_DEPTH(AR_DEPTH),
        .BEAT_DEPTH(BEAT_DEPTH)
    ) merger_i (
        .*
    );

    axi_rd_mem_responder responder_i (
        .*
    );

endmodule

`default_nettype wire

/* design/axi_rd_mem_responder.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_rd_mem_responder (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [axi_rd_pkg::ID_W-1:0]   arid,
    input  logic [axi_rd_pkg::ADDR_W-1:0] araddr,
    input  logic [7:0]                    arlen,
    input  logic [2:0]                    arsize,
    // every burst walks as INCR whatever arburst says
    input  logic [1:0]                    arburst,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [axi_rd_pkg::ID_W-1:0]   rid,
    output logic [axi_rd_pkg::DATA_W-1:0] rdata,
    output logic [1:0]                    rresp,
    output logic                          rlast,
    output logic                          rvalid,
    input  logic                          rready
);

    logic busy;
    logic [7:0] beat_q;
    logic [7:0] len_q;
    logic [2:0] size_q;
    logic [axi_rd_pkg::ID_W-1:0] id_q;
    logic [axi_rd_pkg::ADDR_W-1:0] addr_q;
    logic err_q;
    logic ar_hs;
    logic r_hs;

    assign arready = !busy;
    assign ar_hs = arvalid && arready;
    assign r_hs = rvalid && rready;

    assign rvalid = busy;
    assign rid = id_q;
    assign rdata = {~addr_q, addr_q};
    assign rresp = err_q ? axi_rd_pkg::RESP_SLVERR : axi_rd_pkg::RESP_OKAY;
    assign rlast = (beat_q == len_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            beat_q <= '0;
        end else if (ar_hs) begin
            busy <= 1'b1;
            beat_q <= '0;
        end else if (r_hs) begin
            if (rlast) begin
                busy <= 1'b0;
            end else begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            id_q <= arid;
            addr_q <= araddr;
            len_q <= arlen;
            size_q <= arsize;
            // error decided once from the start address
            err_q <= araddr[31];
        end else if (r_hs) begin
            addr_q <= addr_q + (axi_rd_pkg::ADDR_W'(1) << size_q);
        end
    end

endmodule

`default_nettype wire

/* merger/axi_rd_4_merger.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_rd_4_merger #(
    parameter int MAX_OUTSTANDING = 8,
    parameter int AR_DEPTH = 2,
    parameter int BEAT_DEPTH = 2
) (
    input  logic clk,
    input  logic rst_n,

    input  logic [axi_rd_pkg::ID_W-1:0]   a_arid, b_arid, c_arid, d_arid,
    input  logic [axi_rd_pkg::ADDR_W-1:0] a_araddr, b_araddr, c_araddr, d_araddr,
    input  logic [7:0]                    a_arlen, b_arlen, c_arlen, d_arlen,
    input  logic [2:0]                    a_arsize, b_arsize, c_arsize, d_arsize,
    input  logic [1:0]                    a_arburst, b_arburst, c_arburst, d_arburst,
    input  logic                          a_arvalid, b_arvalid, c_arvalid, d_arvalid,
    output logic                          a_arready, b_arready, c_arready, d_arready,
    output logic [axi_rd_pkg::ID_W-1:0]   a_rid, b_rid, c_rid, d_rid,
    output logic [axi_rd_pkg::DATA_W-1:0] a_rdata, b_rdata, c_rdata, d_rdata,
    output logic [1:0]                    a_rresp, b_rresp, c_rresp, d_rresp,
    output logic                          a_rlast, b_rlast, c_rlast, d_rlast,
    output logic                          a_rvalid, b_rvalid, c_rvalid, d_rvalid,
    input  logic                          a_rready, b_rready, c_rready, d_rready,

    output logic [axi_rd_pkg::ID_W-1:0]   arid,
    output logic [axi_rd_pkg::ADDR_W-1:0] araddr,
    output logic [7:0]                    arlen,
    output logic [2:0]                    arsize,
    output logic [1:0]                    arburst,
    output logic                          arvalid,
    input  logic                          arready,
    input  logic [axi_rd_pkg::ID_W-1:0]   rid,
    input  logic [axi_rd_pkg::DATA_W-1:0] rdata,
    input  logic [1:0]                    rresp,
    input  logic                          rlast,
    input  logic                          rvalid,
    output logic                          rready
);

    localparam logic [3:0][axi_rd_pkg::ID_W-1:0] PORT_TAG = {
        axi_rd_pkg::TAG_D, axi_rd_pkg::TAG_C, axi_rd_pkg::TAG_B, axi_rd_pkg::TAG_A
    };

    axi_rd_pkg::ar_req_t req [4];
    axi_rd_pkg::ar_req_t out_req;
    axi_rd_pkg::r_beat_t in_beat;
    axi_rd_pkg::r_beat_t head_beat;
    logic [axi_rd_pkg::ID_W-1:0] out_tag;
    logic [3:0] pending;
    logic [3:0] ids_full;
    logic [3:0] ids_empty;
    logic [3:0] take;
    logic [3:0] grant;
    logic [3:0] last_done;
    logic [3:0] port_rvalid;
    logic [3:0] port_rready;
    logic beat_empty;
    logic beat_full;
    logic beat_pop;

    rd_port_tracker #(.MAX_OUTSTANDING(MAX_OUTSTANDING), .AR_DEPTH(AR_DEPTH)) a_tracker_i (
        .clk(clk), .rst_n(rst_n),
        .arid(a_arid), .araddr(a_araddr), .arlen(a_arlen), .arsize(a_arsize),
        .arburst(a_arburst), .arvalid(a_arvalid), .arready(a_arready),
        .req(req[0]), .req_pending(pending[0]), .ids_full(ids_full[0]), .grant(grant[0]),
        .head_id(a_rid), .ids_empty(ids_empty[0]), .last_done(last_done[0])
    );

    rd_port_tracker #(.MAX_OUTSTANDING(MAX_OUTSTANDING), .AR_DEPTH(AR_DEPTH)) b_tracker_i (
        .clk(clk), .rst_n(rst_n),
        .arid(b_arid), .araddr(b_araddr), .arlen(b_arlen), .arsize(b_arsize),
        .arburst(b_arburst), .arvalid(b_arvalid), .arready(b_arready),
        .req(req[1]), .req_pending(pending[1]), .ids_full(ids_full[1]), .grant(grant[1]),
        .head_id(b_rid), .ids_empty(ids_empty[1]), .last_done(last_done[1])
    );

    rd_port_tracker #(.MAX_OUTSTANDING(MAX_OUTSTANDING), .AR_DEPTH(AR_DEPTH)) c_tracker_i (
        .clk(clk), .rst_n(rst_n),
        .arid(c_arid), .araddr(c_araddr), .arlen(c_arlen), .arsize(c_arsize),
        .arburst(c_arburst), .arvalid(c_arvalid), .arready(c_arready),
        .req(req[2]), .req_pending(pending[2]), .ids_full(ids_full[2]), .grant(grant[2]),
        .head_id(c_rid), .ids_empty(ids_empty[2]), .last_done(last_done[2])
    );

    rd_port_tracker #(.MAX_OUTSTANDING(MAX_OUTSTANDING), .AR_DEPTH(AR_DEPTH)) d_tracker_i (
        .clk(clk), .rst_n(rst_n),
        .arid(d_arid), .araddr(d_araddr), .arlen(d_arlen), .arsize(d_arsize),
        .arburst(d_arburst), .arvalid(d_arvalid), .arready(d_arready),
        .req(req[3]), .req_pending(pending[3]), .ids_full(ids_full[3]), .grant(grant[3]),
        .head_id(d_rid), .ids_empty(ids_empty[3]), .last_done(last_done[3])
    );

    // fixed priority, port a first
    always_comb begin
        take = '0;
        out_req = '0;
        out_tag = '0;
        for (int i = 0; i < 4; i++) begin
            if (pending[i] && !ids_full[i] && (take == '0)) begin
                take[i] = 1'b1;
                out_req = req[i];
                out_tag = PORT_TAG[i];
            end
        end
    end

    assign arvalid = |take;
    assign arid = out_tag;
    assign araddr = out_req.addr;
    assign arlen = out_req.len;
    assign arsize = out_req.size;
    assign arburst = out_req.burst;
    assign grant = take & {4{arready}};

    assign in_beat = '{id: rid, data: rdata, resp: rresp, last: rlast};
    assign rready = !beat_full;

    rd_sync_fifo #(
        .payload_t(axi_rd_pkg::r_beat_t),
        .DEPTH(BEAT_DEPTH)
    ) beat_fifo_i (
        .clk(clk),
        .rst_n(rst_n),
        .push(rvalid && rready),
        .din(in_beat),
        .pop(beat_pop),
        .dout(head_beat),
        .empty(beat_empty),
        .full(beat_full)
    );

    // head beat goes to the port owning its tag; at most one bit is set
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            port_rvalid[i] = !beat_empty && !ids_empty[i] && (head_beat.id == PORT_TAG[i]);
        end
    end

    assign port_rready = {d_rready, c_rready, b_rready, a_rready};
    assign beat_pop = |(port_rvalid & port_rready);
    assign last_done = port_rvalid & port_rready & {4{head_beat.last}};

    assign a_rvalid = port_rvalid[0];
    assign b_rvalid = port_rvalid[1];
    assign c_rvalid = port_rvalid[2];
    assign d_rvalid = port_rvalid[3];

    assign a_rdata = port_rvalid[0] ? head_beat.data : '0;
    assign b_rdata = port_rvalid[1] ? head_beat.data : '0;
    assign c_rdata = port_rvalid[2] ? head_beat.data : '0;
    assign d_rdata = port_rvalid[3] ? head_beat.data : '0;

    assign a_rresp = port_rvalid[0] ? head_beat.resp : '0;
    assign b_rresp = port_rvalid[1] ? head_beat.resp : '0;
    assign c_rresp = port_rvalid[2] ? head_beat.resp : '0;
    assign d_rresp = port_rvalid[3] ? head_beat.resp : '0;

    assign a_rlast = port_rvalid[0] && head_beat.last;
    assign b_rlast = port_rvalid[1] && head_beat.last;
    assign c_rlast = port_rvalid[2] && head_beat.last;
    assign d_rlast = port_rvalid[3] && head_beat.last;

endmodule

`default_nettype wire

/* merger/rd_port_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

module rd_port_tracker #(
    parameter int MAX_OUTSTANDING = 8,
    parameter int AR_DEPTH = 2
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [axi_rd_pkg::ID_W-1:0]   arid,
    input  logic [axi_rd_pkg::ADDR_W-1:0] araddr,
    input  logic [7:0]                    arlen,
    input  logic [2:0]                    arsize,
    input  logic [1:0]                    arburst,
    input  logic                          arvalid,
    output logic                          arready,
    output axi_rd_pkg::ar_req_t           req,
    output logic                          req_pending,
    output logic                          ids_full,
    input  logic                          grant,
    output logic [axi_rd_pkg::ID_W-1:0]   head_id,
    output logic                          ids_empty,
    input  logic                          last_done
);

    localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

    axi_rd_pkg::ar_req_t new_req;
    logic [CNT_W-1:0] outstanding;
    logic ar_full;
    logic ar_empty;
    logic ar_hs;

    // counted from upstream acceptance, so queued requests also hold a slot
    assign arready = !ar_full && (outstanding < CNT_W'(MAX_OUTSTANDING));
    assign ar_hs = arvalid && arready;
    assign req_pending = !ar_empty;

    assign new_req = '{id: arid, addr: araddr, len: arlen, size: arsize, burst: arburst};

    rd_sync_fifo #(
        .payload_t(axi_rd_pkg::ar_req_t),
        .DEPTH(AR_DEPTH)
    ) req_fifo_i (
        .clk(clk),
        .rst_n(rst_n),
        .push(ar_hs),
        .din(new_req),
        .pop(grant),
        .dout(req),
        .empty(ar_empty),
        .full(ar_full)
    );

    // original IDs of issued bursts, oldest first
    rd_sync_fifo #(
        .payload_t(logic [axi_rd_pkg::ID_W-1:0]),
        .DEPTH(MAX_OUTSTANDING)
    ) id_fifo_i (
        .clk(clk),
        .rst_n(rst_n),
        .push(grant),
        .din(req.id),
        .pop(last_done),
        .dout(head_id),
        .empty(ids_empty),
        .full(ids_full)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= '0;
        end else if (ar_hs && !last_done) begin
            outstanding <= outstanding + 1'b1;
        end else if (!ar_hs && last_done) begin
            outstanding <= outstanding - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/rd_sync_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module rd_sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int DEPTH = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     empty,
    output logic     full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic do_push;
    logic do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    always_comb begin
        count_next = count;
        if (do_push && !do_pop) begin
            count_next = count + 1'b1;
        end else if (!do_push && do_pop) begin
            count_next = count - 1'b1;
        end
    end

    // flags are registered; full reads high in reset so nothing is pushed
    // until the first clock after release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
            empty <= 1'b1;
            full <= 1'b1;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count_next;
            empty <= (count_next == '0);
            full <= (count_next == CNT_W'(DEPTH));
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    assign dout = mem[rd_ptr];

endmodule

`default_nettype wire

/* common/axi_rd_pkg.sv */
`default_nettype none

package axi_rd_pkg;

    localparam int ADDR_W = 32;
    localparam int ID_W = 4;
    localparam int DATA_W = 64;

    // downstream IDs, one per upstream port
    localparam logic [ID_W-1:0] TAG_A = ID_W'(5);
    localparam logic [ID_W-1:0] TAG_B = ID_W'(6);
    localparam logic [ID_W-1:0] TAG_C = ID_W'(7);
    localparam logic [ID_W-1:0] TAG_D = ID_W'(8);

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // one queued read request
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } ar_req_t;

    // one read data beat as it comes back from downstream
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } r_beat_t;

endpackage

`default_nettype wire
